/* common/decoder_pkg.sv */
`default_nettype none

package decoder_pkg;

    // Lattice size: rows (x), columns (z) and measurement rounds (u)
    localparam int GRID_WIDTH_X = 3;
    localparam int GRID_WIDTH_Z = 3;
    localparam int GRID_WIDTH_U = 2;
    localparam int MAX_WEIGHT   = 2; // Same weight on every link

    // One bit minimum per field keeps a degenerate axis addressable
    localparam int X_BIT_WIDTH   = (GRID_WIDTH_X > 1) ? $clog2(GRID_WIDTH_X) : 1;
    localparam int Z_BIT_WIDTH   = (GRID_WIDTH_Z > 1) ? $clog2(GRID_WIDTH_Z) : 1;
    localparam int U_BIT_WIDTH   = (GRID_WIDTH_U > 1) ? $clog2(GRID_WIDTH_U) : 1;
    localparam int ADDRESS_WIDTH = X_BIT_WIDTH + Z_BIT_WIDTH + U_BIT_WIDTH;

    localparam int PU_COUNT_PER_ROUND = GRID_WIDTH_X * GRID_WIDTH_Z;
    localparam int PU_COUNT           = PU_COUNT_PER_ROUND * GRID_WIDTH_U;

    localparam int LINK_BIT_WIDTH = $clog2(MAX_WEIGHT + 1);

    // Slot order in every per-neighbor vector
    localparam int NEIGHBOR_COUNT     = 6;
    localparam int NEIGHBOR_IDX_NORTH = 0; // x - 1
    localparam int NEIGHBOR_IDX_SOUTH = 1; // x + 1
    localparam int NEIGHBOR_IDX_WEST  = 2; // z - 1
    localparam int NEIGHBOR_IDX_EAST  = 3; // z + 1
    localparam int NEIGHBOR_IDX_DOWN  = 4; // Previous round
    localparam int NEIGHBOR_IDX_UP    = 5; // Next round

    // Round in the high field, then x, then z
    typedef logic [ADDRESS_WIDTH-1:0] address_t;

    typedef enum logic [1:0] {
        STAGE_IDLE                = 2'd0,
        STAGE_MEASUREMENT_LOADING = 2'd1,
        STAGE_GROW                = 2'd2,
        STAGE_MERGE               = 2'd3
    } stage_t;

    function automatic address_t pu_address(input int x, input int z, input int u);
        int packed_address;
        packed_address = (u << (X_BIT_WIDTH + Z_BIT_WIDTH)) | (x << Z_BIT_WIDTH) | z;
        return address_t'(packed_address);
    endfunction

    // Flat site index, also the bit order of the top-level outputs
    function automatic int pu_index(input int x, input int z, input int u);
        return x * GRID_WIDTH_Z + z + u * PU_COUNT_PER_ROUND;
    endfunction

endpackage

`default_nettype wire

/* decoder/neighbor_link.sv */
`timescale 1ns/10ps
`default_nettype none

module neighbor_link
    import decoder_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n_i,
    input  stage_t global_stage_i,
    input  logic   a_increase_i,
    input  logic   b_increase_i,
    output logic   fully_grown_o
);

    localparam logic [LINK_BIT_WIDTH-1:0] FULL_GROWTH = LINK_BIT_WIDTH'(MAX_WEIGHT);

    logic [LINK_BIT_WIDTH-1:0] growth_q;
    logic [LINK_BIT_WIDTH:0]   growth_sum; // One spare bit for both ends growing at once

    assign growth_sum = {1'b0, growth_q}
                      + {{LINK_BIT_WIDTH{1'b0}}, a_increase_i}
                      + {{LINK_BIT_WIDTH{1'b0}}, b_increase_i};

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            growth_q <= '0;
        end else begin
            if (global_stage_i == STAGE_MEASUREMENT_LOADING) begin
                growth_q <= '0; // New round starts from zero growth
            end else if (global_stage_i == STAGE_GROW) begin
                if (growth_sum >= {1'b0, FULL_GROWTH}) begin
                    growth_q <= FULL_GROWTH; // Saturate at the link weight
                end else begin
                    growth_q <= growth_sum[LINK_BIT_WIDTH-1:0];
                end
            end
        end
    end

    assign fully_grown_o = (growth_q == FULL_GROWTH);

    // Growth never passes the weight, even with both ends active
    growth_bounded_a : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        growth_q <= FULL_GROWTH
    ) else $error("Link growth above MAX_WEIGHT");

endmodule

`default_nettype wire

/* decoder/processing_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module processing_unit
    import decoder_pkg::*;
(
    input  logic                                clk,
    input  logic                                arst_n_i,
    input  stage_t                              global_stage_i,
    input  address_t                            address_i,
    input  logic                                measurement_i,
    input  logic     [NEIGHBOR_COUNT-1:0]       neighbor_fully_grown_i,
    input  address_t [NEIGHBOR_COUNT-1:0]       neighbor_root_i,
    input  logic     [NEIGHBOR_COUNT-1:0]       neighbor_active_i,
    output logic                                measurement_o,
    output logic                                increase_o,
    output logic                                active_o,
    output logic                                busy_o,
    output address_t                            root_o
);

    logic     defect_q;
    logic     active_q;
    logic     busy_q;
    address_t root_q;

    address_t merged_root;
    logic     merged_active;

    // One hop of flooding across the fully grown links
    always_comb begin
        merged_root   = root_q;
        merged_active = active_q;
        for (int n = 0; n < NEIGHBOR_COUNT; n++) begin
            if (neighbor_fully_grown_i[n]) begin
                if (neighbor_root_i[n] < merged_root) begin
                    merged_root = neighbor_root_i[n];
                end
                merged_active = merged_active | neighbor_active_i[n];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            defect_q <= 1'b0;
            active_q <= 1'b0;
            busy_q   <= 1'b0;
            root_q   <= address_i;
        end else begin
            case (global_stage_i)
                STAGE_MEASUREMENT_LOADING: begin
                    defect_q <= measurement_i; // Round moves down one layer
                    active_q <= measurement_i;
                    root_q   <= address_i;
                    busy_q   <= 1'b0;
                end
                STAGE_MERGE: begin
                    active_q <= merged_active;
                    root_q   <= merged_root;
                    busy_q   <= (merged_root != root_q) || (merged_active != active_q);
                end
                default: begin
                    busy_q <= 1'b0; // Idle and grow hold the cluster state
                end
            endcase
        end
    end

    assign measurement_o = defect_q;
    assign increase_o    = active_q && (global_stage_i == STAGE_GROW);
    assign active_o      = active_q;
    assign root_o        = root_q;
    assign busy_o        = busy_q && (global_stage_i == STAGE_MERGE); // Low as soon as merge ends

    // Roots only ever move toward smaller addresses
    root_bounded_a : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        root_o <= address_i
    ) else $error("Root above own address");

    // Busy reports a change made on a previous merge edge
    busy_in_merge_a : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        busy_o |-> (global_stage_i == STAGE_MERGE) && ($past(global_stage_i) == STAGE_MERGE)
    ) else $error("Busy outside merge");

endmodule

`default_nettype wire

/* design/decoding_graph.sv */
`timescale 1ns/10ps
`default_nettype none

module decoding_graph
    import decoder_pkg::*;
(
    input  logic                              clk,
    input  logic                              arst_n_i,
    input  logic [PU_COUNT_PER_ROUND-1:0]     measurements_i,
    input  stage_t                            global_stage_i,
    output logic [PU_COUNT-1:0]               active_o,
    output logic [ADDRESS_WIDTH*PU_COUNT-1:0] roots_o,
    output logic [PU_COUNT-1:0]               busy_o
);

    logic     [PU_COUNT-1:0] increase;
    logic     [PU_COUNT-1:0] measurement_out;
    address_t [PU_COUNT-1:0] site_root;

    // Links indexed by their lower site, low where the site sits on a face
    logic [PU_COUNT-1:0] grown_x;
    logic [PU_COUNT-1:0] grown_z;
    logic [PU_COUNT-1:0] grown_u;

    assign roots_o = site_root;

    for (genvar u = 0; u < GRID_WIDTH_U; u++) begin : g_u
        for (genvar x = 0; x < GRID_WIDTH_X; x++) begin : g_x
            for (genvar z = 0; z < GRID_WIDTH_Z; z++) begin : g_z
                localparam int IDX = pu_index(x, z, u);

                logic                          meas_in;
                logic     [NEIGHBOR_COUNT-1:0] nb_grown;
                logic     [NEIGHBOR_COUNT-1:0] nb_active;
                address_t [NEIGHBOR_COUNT-1:0] nb_root;

                // Top layer takes the new round, lower layers the one above
                if (u == GRID_WIDTH_U - 1) begin : g_meas_top
                    assign meas_in = measurements_i[x * GRID_WIDTH_Z + z];
                end else begin : g_meas_chain
                    assign meas_in = measurement_out[pu_index(x, z, u + 1)];
                end

                if (x > 0) begin : g_north
                    assign nb_grown[NEIGHBOR_IDX_NORTH]  = grown_x[pu_index(x - 1, z, u)];
                    assign nb_root[NEIGHBOR_IDX_NORTH]   = site_root[pu_index(x - 1, z, u)];
                    assign nb_active[NEIGHBOR_IDX_NORTH] = active_o[pu_index(x - 1, z, u)];
                end else begin : g_north_face
                    assign nb_grown[NEIGHBOR_IDX_NORTH]  = 1'b0;
                    assign nb_root[NEIGHBOR_IDX_NORTH]   = pu_address(x, z, u);
                    assign nb_active[NEIGHBOR_IDX_NORTH] = 1'b0;
                end

                if (x < GRID_WIDTH_X - 1) begin : g_south
                    neighbor_link u_link_x (
                        .clk            (clk),
                        .arst_n_i       (arst_n_i),
                        .global_stage_i (global_stage_i),
                        .a_increase_i   (increase[IDX]),
                        .b_increase_i   (increase[pu_index(x + 1, z, u)]),
                        .fully_grown_o  (grown_x[IDX])
                    );
                    assign nb_root[NEIGHBOR_IDX_SOUTH]   = site_root[pu_index(x + 1, z, u)];
                    assign nb_active[NEIGHBOR_IDX_SOUTH] = active_o[pu_index(x + 1, z, u)];
                end else begin : g_south_face
                    assign grown_x[IDX]                  = 1'b0;
                    assign nb_root[NEIGHBOR_IDX_SOUTH]   = pu_address(x, z, u);
                    assign nb_active[NEIGHBOR_IDX_SOUTH] = 1'b0;
                end
                assign nb_grown[NEIGHBOR_IDX_SOUTH] = grown_x[IDX];

                if (z > 0) begin : g_west
                    assign nb_grown[NEIGHBOR_IDX_WEST]  = grown_z[pu_index(x, z - 1, u)];
                    assign nb_root[NEIGHBOR_IDX_WEST]   = site_root[pu_index(x, z - 1, u)];
                    assign nb_active[NEIGHBOR_IDX_WEST] = active_o[pu_index(x, z - 1, u)];
                end else begin : g_west_face
                    assign nb_grown[NEIGHBOR_IDX_WEST]  = 1'b0;
                    assign nb_root[NEIGHBOR_IDX_WEST]   = pu_address(x, z, u);
                    assign nb_active[NEIGHBOR_IDX_WEST] = 1'b0;
                end

                if (z < GRID_WIDTH_Z - 1) begin : g_east
                    neighbor_link u_link_z (
                        .clk            (clk),
                        .arst_n_i       (arst_n_i),
                        .global_stage_i (global_stage_i),
                        .a_increase_i   (increase[IDX]),
                        .b_increase_i   (increase[pu_index(x, z + 1, u)]),
                        .fully_grown_o  (grown_z[IDX])
                    );
                    assign nb_root[NEIGHBOR_IDX_EAST]   = site_root[pu_index(x, z + 1, u)];
                    assign nb_active[NEIGHBOR_IDX_EAST] = active_o[pu_index(x, z + 1, u)];
                end else begin : g_east_face
                    assign grown_z[IDX]                 = 1'b0;
                    assign nb_root[NEIGHBOR_IDX_EAST]   = pu_address(x, z, u);
                    assign nb_active[NEIGHBOR_IDX_EAST] = 1'b0;
                end
                assign nb_grown[NEIGHBOR_IDX_EAST] = grown_z[IDX];

                if (u > 0) begin : g_down
                    assign nb_grown[NEIGHBOR_IDX_DOWN]  = grown_u[pu_index(x, z, u - 1)];
                    assign nb_root[NEIGHBOR_IDX_DOWN]   = site_root[pu_index(x, z, u - 1)];
                    assign nb_active[NEIGHBOR_IDX_DOWN] = active_o[pu_index(x, z, u - 1)];
                end else begin : g_down_face
                    assign nb_grown[NEIGHBOR_IDX_DOWN]  = 1'b0;
                    assign nb_root[NEIGHBOR_IDX_DOWN]   = pu_address(x, z, u);
                    assign nb_active[NEIGHBOR_IDX_DOWN] = 1'b0;
                end

                if (u < GRID_WIDTH_U - 1) begin : g_up
                    neighbor_link u_link_u (
                        .clk            (clk),
                        .arst_n_i       (arst_n_i),
                        .global_stage_i (global_stage_i),
                        .a_increase_i   (increase[IDX]),
                        .b_increase_i   (increase[pu_index(x, z, u + 1)]),
                        .fully_grown_o  (grown_u[IDX])
                    );
                    assign nb_root[NEIGHBOR_IDX_UP]   = site_root[pu_index(x, z, u + 1)];
                    assign nb_active[NEIGHBOR_IDX_UP] = active_o[pu_index(x, z, u + 1)];
                end else begin : g_up_face
                    assign grown_u[IDX]               = 1'b0;
                    assign nb_root[NEIGHBOR_IDX_UP]   = pu_address(x, z, u);
                    assign nb_active[NEIGHBOR_IDX_UP] = 1'b0;
                end
                assign nb_grown[NEIGHBOR_IDX_UP] = grown_u[IDX];

                processing_unit u_pu (
                    .clk                    (clk),
                    .arst_n_i               (arst_n_i),
                    .global_stage_i         (global_stage_i),
                    .address_i              (pu_address(x, z, u)),
                    .measurement_i          (meas_in),
                    .neighbor_fully_grown_i (nb_grown),
                    .neighbor_root_i        (nb_root),
                    .neighbor_active_i      (nb_active),
                    .measurement_o          (measurement_out[IDX]),
                    .increase_o             (increase[IDX]),
                    .active_o               (active_o[IDX]),
                    .busy_o                 (busy_o[IDX]),
                    .root_o                 (site_root[IDX])
                );
            end
        end
    end

endmodule

`default_nettype wire

/* tb/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Reference copy of the lattice, updated alongside the stimulus
bit       ref_defect [PU_COUNT];
bit       ref_active [PU_COUNT];
address_t ref_root   [PU_COUNT];
int       ref_growth [3][PU_COUNT]; // Axis x, z, u, indexed by the lower site

task automatic restart_clusters();
    int i;
    for (int u = 0; u < GRID_WIDTH_U; u++) begin
        for (int x = 0; x < GRID_WIDTH_X; x++) begin
            for (int z = 0; z < GRID_WIDTH_Z; z++) begin
                i = pu_index(x, z, u);
                ref_active[i] = ref_defect[i]; // Active again only by own defect
                ref_root[i]   = pu_address(x, z, u);
                for (int d = 0; d < 3; d++) begin
                    ref_growth[d][i] = 0;
                end
            end
        end
    end
endtask

task automatic reset_lattice();
    for (int i = 0; i < PU_COUNT; i++) begin
        ref_defect[i] = 1'b0;
    end
    restart_clusters();
endtask

// New round enters the top layer, older rounds move one layer down
task automatic shift_in_round(input logic [PU_COUNT_PER_ROUND-1:0] bits);
    int i;
    for (int u = 0; u < GRID_WIDTH_U; u++) begin
        for (int x = 0; x < GRID_WIDTH_X; x++) begin
            for (int z = 0; z < GRID_WIDTH_Z; z++) begin
                i = pu_index(x, z, u);
                if (u == GRID_WIDTH_U - 1) begin
                    ref_defect[i] = bits[x * GRID_WIDTH_Z + z];
                end else begin
                    ref_defect[i] = ref_defect[pu_index(x, z, u + 1)];
                end
            end
        end
    end
    restart_clusters();
endtask

task automatic step_link(input int d, input int a, input int b, input bit grow,
                         inout bit changed);
    int sum;
    if (grow) begin
        sum = ref_growth[d][a] + int'(ref_active[a]) + int'(ref_active[b]);
        ref_growth[d][a] = (sum > MAX_WEIGHT) ? MAX_WEIGHT : sum;
    end else if (ref_growth[d][a] == MAX_WEIGHT) begin
        if ((ref_root[a] != ref_root[b]) || (ref_active[a] != ref_active[b])) begin
            changed = 1'b1;
        end
        if (ref_root[b] < ref_root[a]) begin
            ref_root[a] = ref_root[b];
        end else begin
            ref_root[b] = ref_root[a];
        end
        ref_active[a] = ref_active[a] | ref_active[b];
        ref_active[b] = ref_active[a];
    end
endtask

// One pass over every link, either growing it or flooding across it
task automatic sweep_links(input bit grow, output bit changed);
    int a;
    changed = 1'b0;
    for (int u = 0; u < GRID_WIDTH_U; u++) begin
        for (int x = 0; x < GRID_WIDTH_X; x++) begin
            for (int z = 0; z < GRID_WIDTH_Z; z++) begin
                a = pu_index(x, z, u);
                if (x < GRID_WIDTH_X - 1) step_link(0, a, pu_index(x + 1, z, u), grow, changed);
                if (z < GRID_WIDTH_Z - 1) step_link(1, a, pu_index(x, z + 1, u), grow, changed);
                if (u < GRID_WIDTH_U - 1) step_link(2, a, pu_index(x, z, u + 1), grow, changed);
            end
        end
    end
endtask

task automatic grow_links();
    bit changed;
    sweep_links(1'b1, changed);
endtask

task automatic flood_roots();
    bit changed;
    changed = 1'b1;
    while (changed) begin
        sweep_links(1'b0, changed); // Repeat until a fixed point
    end
endtask

`endif

/* tb/tb_decoding_graph.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_decoding_graph
    import decoder_pkg::*;
();

    localparam int NUM_TESTS       = 6;
    localparam int CYCLE_BUDGET    = GRID_WIDTH_U + MAX_WEIGHT + PU_COUNT + 20;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * CYCLE_BUDGET + 8; // Reset included

    logic                              clk = 1'b0;
    logic                              arst_n;
    logic [PU_COUNT_PER_ROUND-1:0]     meas_r;
    stage_t                            stage_r;
    logic [PU_COUNT-1:0]               active;
    logic [ADDRESS_WIDTH*PU_COUNT-1:0] roots;
    logic [PU_COUNT-1:0]               busy;

    logic                              check_req = 1'b0;
    logic [PU_COUNT-1:0]               exp_active;
    logic [ADDRESS_WIDTH*PU_COUNT-1:0] exp_roots;
    int                                merge_run = 0; // Merge edges since the stage began
    int                                mismatch_count = 0;
    int                                settle_failures = 0;
    int                                errors_before = 0;
    int                                tests_run = 0;
    int                                tests_failed = 0;

    `include "tb_ref_model.svh"

    decoding_graph UUT (
        .clk            (clk),
        .arst_n_i       (arst_n),
        .measurements_i (meas_r),
        .global_stage_i (stage_r),
        .active_o       (active),
        .roots_o        (roots),
        .busy_o         (busy)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        merge_run <= (stage_r == STAGE_MERGE) ? merge_run + 1 : 0;
    end

    task automatic flag_mismatch(input string what);
        $display("Fail at %0d ns: %s", $time, what);
        mismatch_count++;
    endtask

    outputs_match_a : assert property (
        @(posedge clk) disable iff (!arst_n)
        check_req |-> (active == exp_active) && (roots == exp_roots)
    ) else flag_mismatch("active or roots differ from the model");

    idle_hold_a : assert property (
        @(posedge clk) disable iff (!arst_n)
        (stage_r == STAGE_IDLE) && ($past(stage_r) == STAGE_IDLE)
            |-> $stable(active) && $stable(roots) && (busy == '0)
    ) else flag_mismatch("state moved or busy high during idle");

    busy_in_merge_a : assert property (
        @(posedge clk) disable iff (!arst_n)
        (busy != '0) |-> (stage_r == STAGE_MERGE)
    ) else flag_mismatch("busy high outside merge");

    merge_latency_a : assert property (
        @(posedge clk) disable iff (!arst_n)
        (busy != '0) |-> (merge_run < PU_COUNT)
    ) else flag_mismatch("busy still high after PU_COUNT merge cycles");

    function automatic logic [PU_COUNT_PER_ROUND-1:0] random_round(input bit sparse);
        logic [PU_COUNT_PER_ROUND-1:0] bits;
        for (int i = 0; i < PU_COUNT_PER_ROUND; i++) begin
            bits[i] = sparse ? (($urandom % 6) == 0) : (($urandom % 2) == 1);
        end
        return bits;
    endfunction

    task automatic load_round(input logic [PU_COUNT_PER_ROUND-1:0] bits);
        @(posedge clk);
        stage_r <= STAGE_MEASUREMENT_LOADING;
        meas_r  <= bits;
        shift_in_round(bits);
    endtask

    task automatic grow_cycles(input int k);
        repeat (k) begin
            @(posedge clk);
            stage_r <= STAGE_GROW;
            grow_links();
        end
    endtask

    task automatic run_merge();
        int cycles;
        bit settled;
        cycles  = 0;
        settled = 1'b0;
        @(posedge clk);
        stage_r <= STAGE_MERGE;
        while (!settled && cycles < PU_COUNT + 2) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
            settled = (busy == '0);
        end
        if (!settled) begin
            $display("Merge did not settle within %0d cycles", cycles);
            settle_failures++;
        end
        flood_roots();
    endtask

    // Outputs are compared on the edge after the request
    task automatic checkpoint();
        @(posedge clk);
        stage_r   <= STAGE_IDLE;
        check_req <= 1'b1;
        for (int i = 0; i < PU_COUNT; i++) begin
            exp_active[i]                            <= ref_active[i];
            exp_roots[i*ADDRESS_WIDTH +: ADDRESS_WIDTH] <= ref_root[i];
        end
        @(posedge clk);
        check_req <= 1'b0;
        @(negedge clk); // Action blocks of that edge have run
    endtask

    task automatic finish_test(input string name);
        int errors_now;
        errors_now = mismatch_count + settle_failures;
        tests_run++;
        if (errors_now == errors_before) begin
            $display("Test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", tests_run, name,
                     errors_now - errors_before);
        end
        errors_before = errors_now;
    endtask

    initial begin
        logic [PU_COUNT_PER_ROUND-1:0] round;
        int du;
        int dx;
        int dz;
        void'($urandom(32'h10bc2dc5));
        arst_n  = 1'b0;
        stage_r = STAGE_IDLE;
        meas_r  = '0;
        reset_lattice();
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        checkpoint();
        finish_test("reset");

        repeat (GRID_WIDTH_U) load_round(random_round(1'b0));
        checkpoint();
        finish_test("loading");

        du = $urandom % GRID_WIDTH_U;
        dx = $urandom % GRID_WIDTH_X;
        dz = $urandom % GRID_WIDTH_Z;
        for (int c = 0; c < GRID_WIDTH_U; c++) begin
            round = '0;
            if (c == du) begin
                round[dx * GRID_WIDTH_Z + dz] = 1'b1; // Lands in layer du after U loads
            end
            load_round(round);
        end
        grow_cycles(MAX_WEIGHT);
        run_merge();
        checkpoint();
        finish_test("single defect");

        for (int run = 0; run < 2; run++) begin
            repeat (GRID_WIDTH_U) load_round(random_round(1'b1));
            grow_cycles((run == 0) ? 1 : MAX_WEIGHT + 2);
            run_merge();
            checkpoint();
        end
        finish_test("random defects and saturation");

        repeat (GRID_WIDTH_U) load_round(random_round(1'b1));
        grow_cycles(MAX_WEIGHT);
        run_merge();
        repeat (4) begin
            @(posedge clk);
            stage_r <= STAGE_IDLE;
        end
        checkpoint();
        finish_test("merge latency and idle hold");

        repeat (GRID_WIDTH_U) load_round(random_round(1'b1));
        checkpoint();
        grow_cycles(MAX_WEIGHT);
        run_merge();
        checkpoint();
        finish_test("reload");

        $display("Tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed,
                 mismatch_count + settle_failures);
        if (mismatch_count + settle_failures == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+tb
common/decoder_pkg.sv
decoder/neighbor_link.sv
decoder/processing_unit.sv
design/decoding_graph.sv
tb/tb_decoding_graph.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the decoding graph testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG_FILE=sim.log

verilator --binary --assert -f tb.f --top-module tb_decoding_graph -o tb_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/tb_sim > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "^Done: no errors$" "$LOG_FILE"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG_FILE"
    exit 1
fi
